/* testbench/alu_imm_tests.txt */
// lane op imm12 A source delay dest_PR ROB_index expected, all hex
// source 0 zero, 1 forward, 2 read; delay is OC cycles before the read ack
// bank is {lane, ROB[0]}, read port is ROB[1]
0 0 005 00000010 1 0 01 00 00000015
0 0 fff 12345678 0 0 02 01 ffffffff
0 0 800 00001000 2 0 03 02 00000800
0 1 004 0000000f 2 3 04 03 000000f0
0 1 01f 00000001 1 0 05 04 80000000
0 2 fff fffffffe 2 1 06 05 00000001
0 2 001 00000005 1 0 07 06 00000000
0 3 fff 7fffffff 1 0 08 07 00000001
0 3 001 0000beef 0 0 09 08 00000001
0 4 0ff 12345678 2 5 0a 09 12345687
0 4 f00 12345678 1 0 0b 0a edcba978
0 5 008 80000000 2 2 0c 0b 00800000
0 d 404 80000000 1 0 0d 0c f8000000
0 6 800 00000123 2 0 0e 0d fffff923
0 7 7ff abcdef12 1 0 0f 0e 00000712
0 7 ff0 abcdef12 2 4 10 0f abcdef10
1 0 7ff 00000001 1 0 21 20 00000800
1 0 001 ffffffff 2 2 22 21 00000000
1 1 010 0000abcd 0 0 23 22 00000000
1 1 008 00ff00ff 1 0 24 23 ff00ff00
1 2 800 fffff000 2 1 25 24 00000001
1 2 fff 00000000 0 0 26 25 00000000
1 3 800 fffff800 1 0 27 26 00000000
1 3 010 0000000f 2 0 28 27 00000001
1 4 fff 0f0f0f0f 1 0 29 28 f0f0f0f0
1 5 01f ffffffff 2 6 2a 29 00000001
1 5 004 0000f000 1 0 2b 2a 00000f00
1 d 41f 80000000 2 3 2c 2b ffffffff
1 d 404 7ffffff0 1 0 2d 2c 07ffffff
1 6 0f0 0000000f 2 1 2e 2d 000000ff
1 6 fff 00000000 0 0 2f 2e ffffffff
1 7 0ff deadbeef 1 0 30 2f 000000ef

/* list.f */
verilog/core_types_pkg.sv
verilog/alu.sv
verilog/alu_imm_pipeline.sv
verilog/wb_arbiter.sv
verilog/alu_imm_cluster.sv
testbench/alu_imm_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ALU cluster testbench with Verilator
# exit status is nonzero when the log reports a failure

verilator --binary --timing --assert -f list.f --top-module alu_imm_cluster_tb \
    -o alu_imm_sim || { echo "build failed"; exit 1; }
./obj_dir/alu_imm_sim > sim.log 2>&1
cat sim.log
grep -q 'Test failures found' sim.log && echo "simulation failed" && exit 1
grep -q 'All tests passed!' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* testbench/alu_imm_cluster_tb.sv */
// ------------------------------
// alu_imm_cluster testbench
// plays the issue queue and the PRF around both lanes
// and checks every writeback against the tests file
// ------------------------------

`timescale 1ns/1ps

module alu_imm_cluster_tb;

    localparam int MAX_TESTS = 64;
    localparam int FIELDS = 9;
    localparam int RESET_CYCLES = 10;
    localparam int CYCLES_PER_TEST = 50;
    localparam int DRAIN_CYCLES = 20;

    // columns of the tests file
    localparam int F_LANE = 0;
    localparam int F_OP = 1;
    localparam int F_IMM = 2;
    localparam int F_A = 3;
    localparam int F_SOURCE = 4;
    localparam int F_DELAY = 5;
    localparam int F_PR = 6;
    localparam int F_ROB = 7;
    localparam int F_EXPECTED = 8;

    // A source codes
    localparam int SRC_FORWARD = 1;
    localparam int SRC_READ = 2;

    logic CLK;
    logic nRST;

    // per-lane issue and operand signals
    logic                                          issue_valid [0:1];
    logic [3:0]                                    issue_op [0:1];
    logic [11:0]                                   issue_imm12 [0:1];
    logic                                          issue_A_forward [0:1];
    logic                                          issue_A_is_zero [0:1];
    logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] issue_A_bank [0:1];
    logic [core_types_pkg::LOG_PR_COUNT-1:0]       issue_dest_PR [0:1];
    logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]    issue_ROB_index [0:1];
    logic                                          issue_ready [0:1];
    logic                                          A_reg_read_ack [0:1];
    logic                                          A_reg_read_port [0:1];

    logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port;
    logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0]      forward_data_by_bank;

    logic                                       wb_valid;
    logic [31:0]                                wb_data;
    logic [core_types_pkg::LOG_PR_COUNT-1:0]    wb_PR;
    logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] wb_ROB_index;
    logic                                       wb_ready;

    // test table, one word per column
    logic [31:0] test_words [0:FIELDS*MAX_TESTS-1];
    int          n_tests;
    int          lane_list [0:1][0:MAX_TESTS-1];
    int          lane_count [0:1];
    int          test_of_rob [0:core_types_pkg::ROB_ENTRIES-1];

    // progress per lane
    int   issue_pos [0:1];
    int   wb_pos [0:1];
    int   written;
    logic accepted [0:1];

    // PRF read model, one pending read per lane
    logic rd_pending [0:1];
    int   rd_wait [0:1];
    int   rd_test [0:1];

    // last accepted write, for the fairness check
    logic have_prev;
    int   prev_lane;

    logic [31:0] rng;
    int          data_errors;
    int          pr_errors;
    int          rob_errors;
    int          other_errors;

    alu_imm_cluster DUT (
        .CLK(CLK),
        .nRST(nRST),
        .issue_valid_0(issue_valid[0]),
        .issue_op_0(issue_op[0]),
        .issue_imm12_0(issue_imm12[0]),
        .issue_A_forward_0(issue_A_forward[0]),
        .issue_A_is_zero_0(issue_A_is_zero[0]),
        .issue_A_bank_0(issue_A_bank[0]),
        .issue_dest_PR_0(issue_dest_PR[0]),
        .issue_ROB_index_0(issue_ROB_index[0]),
        .issue_ready_0(issue_ready[0]),
        .A_reg_read_ack_0(A_reg_read_ack[0]),
        .A_reg_read_port_0(A_reg_read_port[0]),
        .issue_valid_1(issue_valid[1]),
        .issue_op_1(issue_op[1]),
        .issue_imm12_1(issue_imm12[1]),
        .issue_A_forward_1(issue_A_forward[1]),
        .issue_A_is_zero_1(issue_A_is_zero[1]),
        .issue_A_bank_1(issue_A_bank[1]),
        .issue_dest_PR_1(issue_dest_PR[1]),
        .issue_ROB_index_1(issue_ROB_index[1]),
        .issue_ready_1(issue_ready[1]),
        .A_reg_read_ack_1(A_reg_read_ack[1]),
        .A_reg_read_port_1(A_reg_read_port[1]),
        .reg_read_data_by_bank_by_port(reg_read_data_by_bank_by_port),
        .forward_data_by_bank(forward_data_by_bank),
        .wb_valid(wb_valid),
        .wb_data(wb_data),
        .wb_PR(wb_PR),
        .wb_ROB_index(wb_ROB_index),
        .wb_ready(wb_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // ------------------------------
    // helpers

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] test_field(input int t, input int column);
        return test_words[t * FIELDS + column];
    endfunction

    // lane 0 owns banks 0 and 1, lane 1 owns banks 2 and 3
    function automatic logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] bank_of(
        input int lane,
        input logic [31:0] rob
    );
        return {lane[0], rob[0]};
    endfunction

    task automatic check_data(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            data_errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_PR(input string name,
                            input logic [core_types_pkg::LOG_PR_COUNT-1:0] actual,
                            input logic [core_types_pkg::LOG_PR_COUNT-1:0] expected);
        if (actual !== expected) begin
            pr_errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_ROB_index(input string name,
                                   input logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] actual,
                                   input logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] expected);
        if (actual !== expected) begin
            rob_errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // ------------------------------
    // setup

    task load_tests();
        logic [31:0] w;
        int l;
        for (int i = 0; i < FIELDS * MAX_TESTS; i++) begin
            test_words[i] = '1;
        end
        $readmemh("testbench/alu_imm_tests.txt", test_words);
        n_tests = 0;
        while (n_tests < MAX_TESTS && test_words[n_tests * FIELDS] != 32'hffffffff) begin
            n_tests++;
        end
        if (n_tests == 0) begin
            other_errors++;
            $display("no tests found in the tests file");
        end
        for (int r = 0; r < core_types_pkg::ROB_ENTRIES; r++) begin
            test_of_rob[r] = -1;
        end
        for (int t = 0; t < n_tests; t++) begin
            w = test_field(t, F_LANE);
            l = int'(w[0]);
            lane_list[l][lane_count[l]] = t;
            lane_count[l] = lane_count[l] + 1;
            w = test_field(t, F_ROB);
            test_of_rob[int'(w[core_types_pkg::LOG_ROB_ENTRIES-1:0])] = t;
        end
    endtask

    task init_inputs();
        nRST = 1'b0;
        wb_ready = 1'b0;
        reg_read_data_by_bank_by_port = '0;
        forward_data_by_bank = '0;
        for (int l = 0; l < 2; l++) begin
            issue_valid[l] = 1'b0;
            issue_op[l] = '0;
            issue_imm12[l] = '0;
            issue_A_forward[l] = 1'b0;
            issue_A_is_zero[l] = 1'b0;
            issue_A_bank[l] = '0;
            issue_dest_PR[l] = '0;
            issue_ROB_index[l] = '0;
            A_reg_read_ack[l] = 1'b0;
            A_reg_read_port[l] = 1'b0;
            lane_count[l] = 0;
            issue_pos[l] = 0;
            wb_pos[l] = 0;
            accepted[l] = 1'b0;
            rd_pending[l] = 1'b0;
            rd_wait[l] = 0;
            rd_test[l] = 0;
        end
        rng = 32'h54b87df6;
        written = 0;
        have_prev = 1'b0;
        prev_lane = 0;
        data_errors = 0;
        pr_errors = 0;
        rob_errors = 0;
        other_errors = 0;
    endtask

    task check_reset_state();
        if (wb_valid !== 1'b0) begin
            other_errors++;
            $display("wb_valid is not low after reset");
        end
        for (int l = 0; l < 2; l++) begin
            if (issue_ready[l] !== 1'b1) begin
                other_errors++;
                $display("issue_ready of lane %0d is not high after reset", l);
            end
        end
    endtask

    // ------------------------------
    // per-cycle drive on the rising edge

    task drive_cycle();
        logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] rd_bus;
        logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0]      fwd_bus;
        logic        ack;
        logic        port;
        logic [31:0] src;
        logic [31:0] rob;
        logic [31:0] w;
        int          t;
        // noise on every bank, lanes overlay their operands below
        for (int b = 0; b < core_types_pkg::PRF_BANK_COUNT; b++) begin
            for (int p = 0; p < 2; p++) begin
                rng = next_random(rng);
                rd_bus[b][p] = rng;
            end
            rng = next_random(rng);
            fwd_bus[b] = rng;
        end
        for (int l = 0; l < 2; l++) begin
            ack = 1'b0;
            port = 1'b0;
            // op accepted at this edge sits in OC next cycle
            if (accepted[l]) begin
                t = lane_list[l][issue_pos[l]];
                issue_pos[l] = issue_pos[l] + 1;
                src = test_field(t, F_SOURCE);
                rob = test_field(t, F_ROB);
                if (src == SRC_FORWARD) begin
                    fwd_bus[bank_of(l, rob)] = test_field(t, F_A);
                end else if (src == SRC_READ) begin
                    rd_pending[l] = 1'b1;
                    rd_wait[l] = int'(test_field(t, F_DELAY));
                    rd_test[l] = t;
                end
            end
            if (rd_pending[l]) begin
                if (rd_wait[l] == 0) begin
                    rob = test_field(rd_test[l], F_ROB);
                    ack = 1'b1;
                    port = rob[1];
                    rd_bus[bank_of(l, rob)][rob[1]] = test_field(rd_test[l], F_A);
                    rd_pending[l] = 1'b0;
                end else begin
                    rd_wait[l] = rd_wait[l] - 1;
                end
            end
            A_reg_read_ack[l] <= ack;
            A_reg_read_port[l] <= port;
            // present the lane's next op, held until accepted
            if (issue_pos[l] < lane_count[l]) begin
                t = lane_list[l][issue_pos[l]];
                src = test_field(t, F_SOURCE);
                issue_valid[l] <= 1'b1;
                w = test_field(t, F_OP);
                issue_op[l] <= w[3:0];
                w = test_field(t, F_IMM);
                issue_imm12[l] <= w[11:0];
                issue_A_forward[l] <= (src == SRC_FORWARD);
                issue_A_is_zero[l] <= (src == 0);
                issue_A_bank[l] <= bank_of(l, test_field(t, F_ROB));
                w = test_field(t, F_PR);
                issue_dest_PR[l] <= w[core_types_pkg::LOG_PR_COUNT-1:0];
                w = test_field(t, F_ROB);
                issue_ROB_index[l] <= w[core_types_pkg::LOG_ROB_ENTRIES-1:0];
            end else begin
                issue_valid[l] <= 1'b0;
            end
        end
        reg_read_data_by_bank_by_port <= rd_bus;
        forward_data_by_bank <= fwd_bus;
        // back-pressure about a quarter of the time
        rng = next_random(rng);
        wb_ready <= (rng[1:0] != 2'b00);
    endtask

    // ------------------------------
    // per-cycle sampling at the falling edge

    task check_writeback();
        logic [31:0] w;
        logic        both;
        int          t;
        int          l;
        int          e;
        both = DUT.WB_valid_0 && DUT.WB_valid_1;
        t = test_of_rob[wb_ROB_index];
        if (t < 0) begin
            other_errors++;
            $display("writeback at %0t carries unknown ROB index %0d", $time, wb_ROB_index);
        end else begin
            w = test_field(t, F_LANE);
            l = int'(w[0]);
            // priority flips after every accepted write
            if (have_prev && both && l == prev_lane) begin
                other_errors++;
                $display("lane %0d won twice in a row with both lanes valid at %0t", l, $time);
            end
            have_prev = 1'b1;
            prev_lane = l;
            if (wb_pos[l] >= lane_count[l]) begin
                other_errors++;
                $display("lane %0d wrote back more results than it issued at %0t", l, $time);
            end else begin
                e = lane_list[l][wb_pos[l]];
                wb_pos[l] = wb_pos[l] + 1;
                written++;
                w = test_field(e, F_ROB);
                check_ROB_index("wb_ROB_index", wb_ROB_index,
                                w[core_types_pkg::LOG_ROB_ENTRIES-1:0]);
                w = test_field(e, F_PR);
                check_PR("wb_PR", wb_PR, w[core_types_pkg::LOG_PR_COUNT-1:0]);
                check_data("wb_data", wb_data, test_field(e, F_EXPECTED));
            end
        end
    endtask

    task sample_cycle();
        for (int l = 0; l < 2; l++) begin
            accepted[l] = issue_valid[l] && issue_ready[l];
        end
        if (wb_valid && wb_ready) begin
            check_writeback();
        end
    endtask

    task run_cycle();
        @(posedge CLK);
        drive_cycle();
        @(negedge CLK);
        sample_cycle();
    endtask

    // ------------------------------
    // main sequence

    initial begin : main
        int total;
        init_inputs();
        load_tests();
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_reset_state();
        while (written < n_tests) begin
            run_cycle();
        end
        // idle tail catches duplicate writebacks
        repeat (DRAIN_CYCLES) begin
            run_cycle();
        end
        total = data_errors + pr_errors + rob_errors + other_errors;
        $display("errors: data %0d, PR %0d, ROB index %0d, other %0d",
                 data_errors, pr_errors, rob_errors, other_errors);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        wait (n_tests > 0);
        repeat (RESET_CYCLES + n_tests * CYCLES_PER_TEST) @(posedge CLK);
        $display("timeout: only %0d of %0d writebacks arrived in time", written, n_tests);
        $display("Test failures found");
        $finish;
    end

endmodule

/* verilog/alu_imm_cluster.sv */
// ------------------------------
// alu_imm_cluster
// two register-immediate ALU pipes sharing one
// PRF write port through a round-robin arbiter
// ------------------------------

`timescale 1ns/1ps

module alu_imm_cluster (
    input  logic CLK,
    input  logic nRST,

    // lane 0 issue and operand
    input  logic                                        issue_valid_0,
    input  logic [3:0]                                  issue_op_0,
    input  logic [11:0]                                 issue_imm12_0,
    input  logic                                        issue_A_forward_0,
    input  logic                                        issue_A_is_zero_0,
    input  logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] issue_A_bank_0,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]       issue_dest_PR_0,
    input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]    issue_ROB_index_0,
    output logic                                        issue_ready_0,
    input  logic                                        A_reg_read_ack_0,
    input  logic                                        A_reg_read_port_0,

    // lane 1 issue and operand
    input  logic                                        issue_valid_1,
    input  logic [3:0]                                  issue_op_1,
    input  logic [11:0]                                 issue_imm12_1,
    input  logic                                        issue_A_forward_1,
    input  logic                                        issue_A_is_zero_1,
    input  logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] issue_A_bank_1,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]       issue_dest_PR_1,
    input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]    issue_ROB_index_1,
    output logic                                        issue_ready_1,
    input  logic                                        A_reg_read_ack_1,
    input  logic                                        A_reg_read_port_1,

    // shared PRF buses
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0]      forward_data_by_bank,

    // PRF write port
    output logic                                        wb_valid,
    output logic [31:0]                                 wb_data,
    output logic [core_types_pkg::LOG_PR_COUNT-1:0]       wb_PR,
    output logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]    wb_ROB_index,
    input  logic                                        wb_ready
);

    // pipe to arbiter
    logic                                       WB_valid_0;
    logic                                       WB_valid_1;
    logic [31:0]                                WB_data_0;
    logic [31:0]                                WB_data_1;
    logic [core_types_pkg::LOG_PR_COUNT-1:0]    WB_PR_0;
    logic [core_types_pkg::LOG_PR_COUNT-1:0]    WB_PR_1;
    logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] WB_ROB_index_0;
    logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] WB_ROB_index_1;
    logic                                       WB_ready_0;
    logic                                       WB_ready_1;

    alu_imm_pipeline pipe_0 (
        .CLK(CLK),
        .nRST(nRST),
        .issue_valid(issue_valid_0),
        .issue_op(issue_op_0),
        .issue_imm12(issue_imm12_0),
        .issue_A_forward(issue_A_forward_0),
        .issue_A_is_zero(issue_A_is_zero_0),
        .issue_A_bank(issue_A_bank_0),
        .issue_dest_PR(issue_dest_PR_0),
        .issue_ROB_index(issue_ROB_index_0),
        .issue_ready(issue_ready_0),
        .A_reg_read_ack(A_reg_read_ack_0),
        .A_reg_read_port(A_reg_read_port_0),
        .reg_read_data_by_bank_by_port(reg_read_data_by_bank_by_port),
        .forward_data_by_bank(forward_data_by_bank),
        .WB_valid(WB_valid_0),
        .WB_data(WB_data_0),
        .WB_PR(WB_PR_0),
        .WB_ROB_index(WB_ROB_index_0),
        .WB_ready(WB_ready_0)
    );

    alu_imm_pipeline pipe_1 (
        .CLK(CLK),
        .nRST(nRST),
        .issue_valid(issue_valid_1),
        .issue_op(issue_op_1),
        .issue_imm12(issue_imm12_1),
        .issue_A_forward(issue_A_forward_1),
        .issue_A_is_zero(issue_A_is_zero_1),
        .issue_A_bank(issue_A_bank_1),
        .issue_dest_PR(issue_dest_PR_1),
        .issue_ROB_index(issue_ROB_index_1),
        .issue_ready(issue_ready_1),
        .A_reg_read_ack(A_reg_read_ack_1),
        .A_reg_read_port(A_reg_read_port_1),
        .reg_read_data_by_bank_by_port(reg_read_data_by_bank_by_port),
        .forward_data_by_bank(forward_data_by_bank),
        .WB_valid(WB_valid_1),
        .WB_data(WB_data_1),
        .WB_PR(WB_PR_1),
        .WB_ROB_index(WB_ROB_index_1),
        .WB_ready(WB_ready_1)
    );

    wb_arbiter arbiter (
        .CLK(CLK),
        .nRST(nRST),
        .WB_valid_0(WB_valid_0),
        .WB_data_0(WB_data_0),
        .WB_PR_0(WB_PR_0),
        .WB_ROB_index_0(WB_ROB_index_0),
        .WB_ready_0(WB_ready_0),
        .WB_valid_1(WB_valid_1),
        .WB_data_1(WB_data_1),
        .WB_PR_1(WB_PR_1),
        .WB_ROB_index_1(WB_ROB_index_1),
        .WB_ready_1(WB_ready_1),
        .wb_valid(wb_valid),
        .wb_data(wb_data),
        .wb_PR(wb_PR),
        .wb_ROB_index(wb_ROB_index),
        .wb_ready(wb_ready)
    );

endmodule

/* verilog/wb_arbiter.sv */
// ------------------------------
// wb_arbiter
// round-robin merge of two writeback lanes onto
// the single PRF write port
// ------------------------------

`timescale 1ns/1ps

module wb_arbiter (
    input  logic CLK,
    input  logic nRST,

    // lane 0
    input  logic                                     WB_valid_0,
    input  logic [31:0]                              WB_data_0,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]    WB_PR_0,
    input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] WB_ROB_index_0,
    output logic                                     WB_ready_0,

    // lane 1
    input  logic                                     WB_valid_1,
    input  logic [31:0]                              WB_data_1,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]    WB_PR_1,
    input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] WB_ROB_index_1,
    output logic                                     WB_ready_1,

    // PRF write port
    output logic                                     wb_valid,
    output logic [31:0]                              wb_data,
    output logic [core_types_pkg::LOG_PR_COUNT-1:0]    wb_PR,
    output logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] wb_ROB_index,
    input  logic                                     wb_ready
);

    // 0 favours lane 0, 1 favours lane 1
    logic prio;
    logic grant_0;
    logic grant_1;

    assign grant_1 = WB_valid_1 & (~WB_valid_0 | prio);
    assign grant_0 = WB_valid_0 & ~grant_1;

    assign WB_ready_0 = grant_0 & wb_ready;
    assign WB_ready_1 = grant_1 & wb_ready;

    assign wb_valid = grant_0 | grant_1;
    assign wb_data = grant_1 ? WB_data_1 : WB_data_0;
    assign wb_PR = grant_1 ? WB_PR_1 : WB_PR_0;
    assign wb_ROB_index = grant_1 ? WB_ROB_index_1 : WB_ROB_index_0;

    // winner of an accepted write hands priority to the other lane
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            prio <= 1'b0;
        end else if (wb_valid & wb_ready) begin
            prio <= grant_0;
        end
    end

    // ------------------------------
    // checks

    // a lane that just wrote yields to a waiting neighbour
    a_rr_after_0: assert property (
        @(posedge CLK) disable iff (~nRST)
        (grant_0 && wb_ready) |=> (WB_valid_1 |-> grant_1)
    ) else $error("lane 0 kept priority after an accepted write");

    a_rr_after_1: assert property (
        @(posedge CLK) disable iff (~nRST)
        (grant_1 && wb_ready) |=> (WB_valid_0 |-> grant_0)
    ) else $error("lane 1 kept priority after an accepted write");

endmodule

/* verilog/alu_imm_pipeline.sv */
// ------------------------------
// alu_imm_pipeline
// register-immediate ALU pipe with an operand
// collect stage and a stallable writeback stage
// ------------------------------

`timescale 1ns/1ps

module alu_imm_pipeline (
    input  logic CLK,
    input  logic nRST,

    // issued op from the issue queue
    input  logic                                        issue_valid,
    input  logic [3:0]                                  issue_op,
    input  logic [11:0]                                 issue_imm12,
    input  logic                                        issue_A_forward,
    input  logic                                        issue_A_is_zero,
    input  logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] issue_A_bank,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]       issue_dest_PR,
    input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]    issue_ROB_index,
    output logic                                        issue_ready,

    // register read and forward data from the PRF
    input  logic                                        A_reg_read_ack,
    input  logic                                        A_reg_read_port,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0]      forward_data_by_bank,

    // writeback toward the arbiter
    output logic                                        WB_valid,
    output logic [31:0]                                 WB_data,
    output logic [core_types_pkg::LOG_PR_COUNT-1:0]       WB_PR,
    output logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]    WB_ROB_index,
    input  logic                                        WB_ready
);

    logic stall_WB;
    logic stall_OC;

    // OC stage
    logic                                          valid_OC;
    logic [3:0]                                    op_OC;
    logic [11:0]                                   imm12_OC;
    logic                                          A_saved_OC;
    logic                                          A_forward_OC;
    logic                                          A_is_zero_OC;
    logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] A_bank_OC;
    logic [core_types_pkg::LOG_PR_COUNT-1:0]       dest_PR_OC;
    logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]    ROB_index_OC;
    logic [31:0]                                   A_saved_data_OC;
    logic [31:0]                                   A_OC;
    logic                                          A_present_OC;
    logic                                          launch_OC;

    // WB stage
    logic [3:0]  WB_op;
    logic [31:0] WB_A;
    logic [11:0] WB_imm12;
    logic [31:0] WB_B;

    // ------------------------------
    // stall control

    assign stall_WB = WB_valid & ~WB_ready;
    // only matters when OC has something to push
    assign stall_OC = stall_WB & valid_OC;

    // ------------------------------
    // operand collect

    assign A_present_OC = A_is_zero_OC | A_saved_OC | A_forward_OC | A_reg_read_ack;
    assign launch_OC = ~stall_OC & A_present_OC;
    assign issue_ready = ~valid_OC | launch_OC;

    // A source select, saved value wins over live buses
    always_comb begin
        if (A_is_zero_OC) begin
            A_OC = 32'h0;
        end else if (A_saved_OC) begin
            A_OC = A_saved_data_OC;
        end else if (A_forward_OC) begin
            A_OC = forward_data_by_bank[A_bank_OC];
        end else begin
            A_OC = reg_read_data_by_bank_by_port[A_bank_OC][A_reg_read_port];
        end
    end

    // OC control flags
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_OC <= 1'b0;
            A_saved_OC <= 1'b0;
            A_forward_OC <= 1'b0;
            A_is_zero_OC <= 1'b0;
        end else if (~issue_ready) begin
            // holding, remember whether A showed up this cycle
            A_saved_OC <= A_saved_OC | A_forward_OC | A_reg_read_ack;
            // forward bus is only good for the first OC cycle
            A_forward_OC <= 1'b0;
        end else begin
            valid_OC <= issue_valid;
            A_saved_OC <= 1'b0;
            A_forward_OC <= issue_A_forward;
            A_is_zero_OC <= issue_A_is_zero;
        end
    end

    // OC payload
    always_ff @(posedge CLK) begin
        // latest collected A, only trusted once A_saved_OC is set
        A_saved_data_OC <= A_OC;
        if (issue_ready) begin
            op_OC <= issue_op;
            imm12_OC <= issue_imm12;
            A_bank_OC <= issue_A_bank;
            dest_PR_OC <= issue_dest_PR;
            ROB_index_OC <= issue_ROB_index;
        end
    end

    // ------------------------------
    // writeback

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            WB_valid <= 1'b0;
        end else if (~stall_WB) begin
            WB_valid <= valid_OC & launch_OC;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_WB) begin
            WB_op <= op_OC;
            WB_A <= A_OC;
            WB_imm12 <= imm12_OC;
            WB_PR <= dest_PR_OC;
            WB_ROB_index <= ROB_index_OC;
        end
    end

    // sign-extended immediate as operand B
    assign WB_B = {{20{WB_imm12[11]}}, WB_imm12};

    alu alu_wb (
        .op(WB_op),
        .A(WB_A),
        .B(WB_B),
        .out(WB_data)
    );

    // stalled writeback must present the same result next cycle
    a_wb_hold: assert property (
        @(posedge CLK) disable iff (~nRST)
        (WB_valid && !WB_ready) |=>
            (WB_valid && $stable(WB_data) && $stable(WB_PR) && $stable(WB_ROB_index))
    ) else $error("writeback changed while stalled");

endmodule

/* verilog/alu.sv */
// ------------------------------
// alu
// combinational 32-bit integer ALU, op selected
// by the 4-bit {funct7[5], funct3} code
// ------------------------------

`timescale 1ns/1ps

module alu (
    input  logic [3:0]  op,
    input  logic [31:0] A,
    input  logic [31:0] B,
    output logic [31:0] out
);

    // shift amount is the low five bits of B
    logic [4:0] shamt;

    assign shamt = B[4:0];

    always_comb begin
        case (op)
            core_types_pkg::ALU_ADD: begin
                out = A + B;
            end
            core_types_pkg::ALU_SUB: begin
                out = A - B;
            end
            core_types_pkg::ALU_SLL: begin
                out = A << shamt;
            end
            core_types_pkg::ALU_SRL: begin
                out = A >> shamt;
            end
            core_types_pkg::ALU_SRA: begin
                out = $signed(A) >>> shamt;
            end
            core_types_pkg::ALU_SLT: begin
                out = {31'h0, $signed(A) < $signed(B)};
            end
            core_types_pkg::ALU_SLTU: begin
                out = {31'h0, A < B};
            end
            core_types_pkg::ALU_XOR: begin
                out = A ^ B;
            end
            core_types_pkg::ALU_OR: begin
                out = A | B;
            end
            core_types_pkg::ALU_AND: begin
                out = A & B;
            end
            // unused encodings
            default: begin
                out = 32'h0;
            end
        endcase
    end

endmodule

/* verilog/core_types_pkg.sv */
// ------------------------------
// core types package
// core sizes and ALU op codes shared by the
// register-immediate ALU cluster
// ------------------------------

package core_types_pkg;

    // ------------------------------
    // physical register file

    // number of PRF banks, one read port pair per bank
    localparam int PRF_BANK_COUNT = 4;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

    // physical register tags
    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);

    // ------------------------------
    // reorder buffer

    localparam int ROB_ENTRIES = 64;
    localparam int LOG_ROB_ENTRIES = $clog2(ROB_ENTRIES);

    // ------------------------------
    // ALU op codes
    // {funct7[5], funct3}

    // add, also addi
    localparam logic [3:0] ALU_ADD = 4'b0000;
    // shift left logical
    localparam logic [3:0] ALU_SLL = 4'b0001;
    // set less than, signed
    localparam logic [3:0] ALU_SLT = 4'b0010;
    // set less than, unsigned
    localparam logic [3:0] ALU_SLTU = 4'b0011;
    localparam logic [3:0] ALU_XOR = 4'b0100;
    // shift right logical
    localparam logic [3:0] ALU_SRL = 4'b0101;
    localparam logic [3:0] ALU_OR = 4'b0110;
    localparam logic [3:0] ALU_AND = 4'b0111;

    // register-register only, never issued with an immediate
    localparam logic [3:0] ALU_SUB = 4'b1000;

    // shift right arithmetic
    localparam logic [3:0] ALU_SRA = 4'b1101;

endpackage
